// File: source/issue_pkg.sv
`default_nettype none

package issue_pkg;

  localparam int WORD_W        = 32;                     // datapath width
  localparam int NUM_TAGS      = 32;                     // physical registers
  localparam int TAG_W         = $clog2(NUM_TAGS);       // 5 bit tags
  localparam int ISSUE_ENTRIES = 8;                      // issue table depth
  localparam int ENTRY_W       = $clog2(ISSUE_ENTRIES);  // slot index width
  localparam int COUNT_W       = $clog2(ISSUE_ENTRIES) + 1; // must hold 0..8
  localparam int NUM_FU        = 2;                      // alu + mul
  localparam int FU_W          = $clog2(NUM_FU);
  localparam int OP_W          = 3;
  localparam int MUL_STAGES    = 3;                      // multiplier depth

  typedef logic [WORD_W-1:0]  word_t;       // data word
  typedef logic [TAG_W-1:0]   tag_t;        // physical tag
  typedef logic [ENTRY_W-1:0] entry_idx_t;  // table slot
  typedef logic [COUNT_W-1:0] count_t;      // occupancy
  typedef logic [FU_W-1:0]    fu_sel_t;     // unit select
  typedef logic [OP_W-1:0]    opcode_t;     // operation

  localparam fu_sel_t FU_ALU = 1'b0;
  localparam fu_sel_t FU_MUL = 1'b1;

  localparam opcode_t OP_ADD = 3'd0;
  localparam opcode_t OP_SUB = 3'd1;
  localparam opcode_t OP_AND = 3'd2;
  localparam opcode_t OP_OR  = 3'd3;
  localparam opcode_t OP_XOR = 3'd4;
  localparam opcode_t OP_MUL = 3'd5;  // only meaningful on the multiplier

endpackage

`default_nettype wire

// File: source/issue_if.sv
`timescale 1ns/1ns
`default_nettype none

// issue bundle from the table to both units
// units never stall, so there is no ready
interface issue_if
  import issue_pkg::*;
  ();

  logic    valid;      // one issue this cycle
  fu_sel_t fu_sel;     // which unit takes it
  opcode_t opcode;     // alu op or mul
  tag_t    dest_tag;   // tag for the result bus
  word_t   src1_data;  // operand a
  word_t   src2_data;  // operand b, reg value or zero-ext imm

  modport tbl (
    output valid,
    output fu_sel,
    output opcode,
    output dest_tag,
    output src1_data,
    output src2_data
  );

  modport unit (
    input valid,
    input fu_sel,
    input opcode,
    input dest_tag,
    input src1_data,
    input src2_data
  );

endinterface

`default_nettype wire

// File: source/phys_reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module phys_reg_file
  import issue_pkg::*;
  ( input  logic  clk_i
  , input  logic  reset_i
  // dispatch reads and allocation
  , input  tag_t  src1_tag_i
  , input  tag_t  src2_tag_i
  , input  tag_t  dest_tag_i
  , input  logic  alloc_i         // dispatch accepted this cycle
  // result buses
  , input  logic  alu_res_valid_i
  , input  tag_t  alu_res_tag_i
  , input  word_t alu_res_data_i
  , input  logic  mul_res_valid_i
  , input  tag_t  mul_res_tag_i
  , input  word_t mul_res_data_i
  , input  logic  ld_res_valid_i
  , input  tag_t  ld_res_tag_i
  , input  word_t ld_res_data_i
  // read results
  , output logic  src1_rdy_o
  , output word_t src1_val_o
  , output logic  src2_rdy_o
  , output word_t src2_val_o
  );

  word_t               val_q [NUM_TAGS];
  logic [NUM_TAGS-1:0] rdy_q;            // value present

  tag_t  rd_tag [2];
  logic  rd_rdy [2];
  word_t rd_val [2];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int t = 0; t < NUM_TAGS; t++) begin
        val_q[t] <= '0;
      end
      rdy_q <= '1;  // everything starts ready at 0
    end else begin
      if (ld_res_valid_i) begin
        val_q[ld_res_tag_i] <= ld_res_data_i;
        rdy_q[ld_res_tag_i] <= 1'b1;
      end
      if (mul_res_valid_i) begin
        val_q[mul_res_tag_i] <= mul_res_data_i;
        rdy_q[mul_res_tag_i] <= 1'b1;
      end
      if (alu_res_valid_i) begin
        val_q[alu_res_tag_i] <= alu_res_data_i;
        rdy_q[alu_res_tag_i] <= 1'b1;
      end
      if (alloc_i) begin
        rdy_q[dest_tag_i] <= 1'b0;  // new producer pending
      end
    end
  end

  assign rd_tag[0] = src1_tag_i;
  assign rd_tag[1] = src2_tag_i;

  // stored value, overridden by any bus carrying the tag now
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      rd_rdy[p] = rdy_q[rd_tag[p]];
      rd_val[p] = val_q[rd_tag[p]];
      if (ld_res_valid_i && (ld_res_tag_i == rd_tag[p])) begin
        rd_rdy[p] = 1'b1;
        rd_val[p] = ld_res_data_i;
      end
      if (mul_res_valid_i && (mul_res_tag_i == rd_tag[p])) begin
        rd_rdy[p] = 1'b1;
        rd_val[p] = mul_res_data_i;
      end
      if (alu_res_valid_i && (alu_res_tag_i == rd_tag[p])) begin
        rd_rdy[p] = 1'b1;
        rd_val[p] = alu_res_data_i;
      end
    end
  end

  assign src1_rdy_o = rd_rdy[0];
  assign src1_val_o = rd_val[0];
  assign src2_rdy_o = rd_rdy[1];
  assign src2_val_o = rd_val[1];

endmodule

`default_nettype wire

// File: source/issue_table.sv
`timescale 1ns/1ns
`default_nettype none

module issue_table
  import issue_pkg::*;
  ( input  logic    clk_i
  , input  logic    reset_i
  // dispatch port
  , input  logic    dispatch_valid_i
  , output logic    dispatch_ready_o
  , input  tag_t    dest_tag_i
  , input  tag_t    src1_tag_i
  , input  tag_t    src2_tag_i
  , input  logic    use_imm_i       // src2 field is an immediate
  , input  opcode_t opcode_i
  , input  fu_sel_t fu_sel_i
  // register file reads, already bypassed
  , input  logic    src1_rdy_i
  , input  word_t   src1_val_i
  , input  logic    src2_rdy_i
  , input  word_t   src2_val_i
  // result buses
  , input  logic    alu_res_valid_i
  , input  tag_t    alu_res_tag_i
  , input  word_t   alu_res_data_i
  , input  logic    mul_res_valid_i
  , input  tag_t    mul_res_tag_i
  , input  word_t   mul_res_data_i
  , input  logic    ld_res_valid_i
  , input  tag_t    ld_res_tag_i
  , input  word_t   ld_res_data_i
  // to the units
  , issue_if.tbl    issue_o
  );

  localparam int NUM_BUS = 3;  // alu, mul, load

  logic [ISSUE_ENTRIES-1:0] ent_valid_q;          // slot occupied
  tag_t                     ent_dest_q   [ISSUE_ENTRIES];
  opcode_t                  ent_op_q     [ISSUE_ENTRIES];
  fu_sel_t                  ent_fu_q     [ISSUE_ENTRIES];
  tag_t                     ent_s1_tag_q [ISSUE_ENTRIES];
  tag_t                     ent_s2_tag_q [ISSUE_ENTRIES]; // imm bits when use_imm
  logic [ISSUE_ENTRIES-1:0] ent_s1_rdy_q;
  logic [ISSUE_ENTRIES-1:0] ent_s2_rdy_q;
  word_t                    ent_s1_val_q [ISSUE_ENTRIES];
  word_t                    ent_s2_val_q [ISSUE_ENTRIES];

  entry_idx_t order_q [ISSUE_ENTRIES];  // slot indexes, oldest at 0
  entry_idx_t order_n [ISSUE_ENTRIES];
  count_t     count_q;                  // valid positions in order_q
  count_t     count_n;

  logic  bus_v    [NUM_BUS];
  tag_t  bus_tag  [NUM_BUS];
  word_t bus_data [NUM_BUS];

  logic [ISSUE_ENTRIES-1:0] s1_wake;
  logic [ISSUE_ENTRIES-1:0] s2_wake;
  word_t                    s1_wake_val [ISSUE_ENTRIES];
  word_t                    s2_wake_val [ISSUE_ENTRIES];

  logic [ISSUE_ENTRIES-1:0] ent_ready;  // by slot
  logic [ISSUE_ENTRIES-1:0] ord_ready;  // by age position
  entry_idx_t               pick_pos;   // age position of winner
  entry_idx_t               chosen;     // slot of winner
  entry_idx_t               free_idx;   // lowest empty slot
  logic                     pick_found;
  logic                     accept;
  logic                     issue;
  count_t                   ins_pos;    // append position after compaction
  logic                     new_s2_rdy;
  word_t                    new_s2_val;

  assign bus_v[0]    = alu_res_valid_i;
  assign bus_tag[0]  = alu_res_tag_i;
  assign bus_data[0] = alu_res_data_i;
  assign bus_v[1]    = mul_res_valid_i;
  assign bus_tag[1]  = mul_res_tag_i;
  assign bus_data[1] = mul_res_data_i;
  assign bus_v[2]    = ld_res_valid_i;
  assign bus_tag[2]  = ld_res_tag_i;
  assign bus_data[2] = ld_res_data_i;

  // tag compare of every source against every bus
  always_comb begin
    for (int e = 0; e < ISSUE_ENTRIES; e++) begin
      s1_wake[e]     = 1'b0;
      s2_wake[e]     = 1'b0;
      s1_wake_val[e] = '0;
      s2_wake_val[e] = '0;
      for (int b = 0; b < NUM_BUS; b++) begin
        if (bus_v[b] && (bus_tag[b] == ent_s1_tag_q[e])) begin
          s1_wake[e]     = 1'b1;
          s1_wake_val[e] = bus_data[b];
        end
        if (bus_v[b] && (bus_tag[b] == ent_s2_tag_q[e])) begin
          s2_wake[e]     = 1'b1;
          s2_wake_val[e] = bus_data[b];
        end
      end
    end
  end

  // oldest ready wins, walked in age order
  always_comb begin
    ent_ready  = ent_valid_q & ent_s1_rdy_q & ent_s2_rdy_q;
    pick_found = 1'b0;
    pick_pos   = '0;
    for (int k = ISSUE_ENTRIES - 1; k >= 0; k--) begin
      ord_ready[k] = (count_t'(k) < count_q) && ent_ready[order_q[k]];
      if (ord_ready[k]) begin  // lowest position sticks
        pick_found = 1'b1;
        pick_pos   = entry_idx_t'(k);
      end
    end
  end

  assign chosen = order_q[pick_pos];

  // priority encode empty slots
  always_comb begin
    free_idx = '0;
    for (int e = ISSUE_ENTRIES - 1; e >= 0; e--) begin
      if (!ent_valid_q[e]) begin
        free_idx = entry_idx_t'(e);
      end
    end
  end

  assign dispatch_ready_o = (count_q != count_t'(ISSUE_ENTRIES));  // current count only
  assign accept           = dispatch_valid_i && dispatch_ready_o;
  assign issue            = pick_found;
  assign ins_pos          = count_q - count_t'(issue);
  assign count_n          = count_q + count_t'(accept) - count_t'(issue);

  // compact past the issued position, then append
  always_comb begin
    for (int k = 0; k < ISSUE_ENTRIES - 1; k++) begin
      order_n[k] = (issue && (k >= int'(pick_pos))) ? order_q[k+1] : order_q[k];
    end
    order_n[ISSUE_ENTRIES-1] = order_q[ISSUE_ENTRIES-1];  // stale past count
    if (accept) begin
      order_n[entry_idx_t'(ins_pos)] = free_idx;
    end
  end

  assign new_s2_rdy = use_imm_i || src2_rdy_i;
  assign new_s2_val = use_imm_i ? word_t'(src2_tag_i) : src2_val_i;  // zero-ext imm

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q     <= '0;
      ent_valid_q <= '0;
    end else begin
      count_q <= count_n;
      if (issue) begin
        ent_valid_q[chosen] <= 1'b0;  // freed at the issue edge
      end
      if (accept) begin
        ent_valid_q[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    order_q <= order_n;
    for (int e = 0; e < ISSUE_ENTRIES; e++) begin
      if (s1_wake[e] && !ent_s1_rdy_q[e]) begin  // only waiting sources
        ent_s1_rdy_q[e] <= 1'b1;
        ent_s1_val_q[e] <= s1_wake_val[e];
      end
      if (s2_wake[e] && !ent_s2_rdy_q[e]) begin
        ent_s2_rdy_q[e] <= 1'b1;
        ent_s2_val_q[e] <= s2_wake_val[e];
      end
    end
    if (accept) begin  // slot was empty, so no wakeup conflict
      ent_dest_q[free_idx]   <= dest_tag_i;
      ent_op_q[free_idx]     <= opcode_i;
      ent_fu_q[free_idx]     <= fu_sel_i;
      ent_s1_tag_q[free_idx] <= src1_tag_i;
      ent_s2_tag_q[free_idx] <= src2_tag_i;
      ent_s1_rdy_q[free_idx] <= src1_rdy_i;
      ent_s1_val_q[free_idx] <= src1_val_i;
      ent_s2_rdy_q[free_idx] <= new_s2_rdy;
      ent_s2_val_q[free_idx] <= new_s2_val;
    end
  end

  assign issue_o.valid     = issue;
  assign issue_o.fu_sel    = ent_fu_q[chosen];
  assign issue_o.opcode    = ent_op_q[chosen];
  assign issue_o.dest_tag  = ent_dest_q[chosen];
  assign issue_o.src1_data = ent_s1_val_q[chosen];
  assign issue_o.src2_data = ent_s2_val_q[chosen];

endmodule

`default_nettype wire

// File: source/alu_unit.sv
`timescale 1ns/1ns
`default_nettype none

module alu_unit
  import issue_pkg::*;
  ( input  logic  clk_i
  , input  logic  reset_i
  , issue_if.unit issue_i
  // result bus
  , output logic  res_valid_o
  , output tag_t  res_tag_o
  , output word_t res_data_o
  );

  logic  fire;    // bundle targets this unit
  word_t result;

  assign fire = issue_i.valid && (issue_i.fu_sel == FU_ALU);

  always_comb begin
    case (issue_i.opcode)
      OP_ADD:  result = issue_i.src1_data + issue_i.src2_data;
      OP_SUB:  result = issue_i.src1_data - issue_i.src2_data;
      OP_AND:  result = issue_i.src1_data & issue_i.src2_data;
      OP_OR:   result = issue_i.src1_data | issue_i.src2_data;
      OP_XOR:  result = issue_i.src1_data ^ issue_i.src2_data;
      default: result = '0;  // mul never routed here
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= fire;  // one cycle after issue
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      res_tag_o  <= issue_i.dest_tag;
      res_data_o <= result;
    end
  end

endmodule

`default_nettype wire

// File: source/mul_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mul_unit
  import issue_pkg::*;
  ( input  logic  clk_i
  , input  logic  reset_i
  , issue_if.unit issue_i
  // result bus
  , output logic  res_valid_o
  , output tag_t  res_tag_o
  , output word_t res_data_o
  );

  localparam int HALF = WORD_W / 2;

  logic                  fire;
  word_t                 pp_lo;                // a * b[15:0]
  word_t                 pp_hi;                // a * b[31:16], low half used
  logic [MUL_STAGES-1:0] v_q;                  // valid per stage
  tag_t                  tag_q  [MUL_STAGES];
  word_t                 prod_q [MUL_STAGES];  // partial then full product
  logic [HALF-1:0]       hi_q;                 // upper partial, pre-shift

  assign fire  = issue_i.valid && (issue_i.fu_sel == FU_MUL);
  assign pp_lo = issue_i.src1_data * word_t'(issue_i.src2_data[HALF-1:0]);
  assign pp_hi = issue_i.src1_data * word_t'(issue_i.src2_data[WORD_W-1:HALF]);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_q <= '0;
    end else begin
      v_q <= {v_q[MUL_STAGES-2:0], fire};
    end
  end

  always_ff @(posedge clk_i) begin
    tag_q[0]  <= issue_i.dest_tag;          // stage 1 split product
    prod_q[0] <= pp_lo;
    hi_q      <= pp_hi[HALF-1:0];
    tag_q[1]  <= tag_q[0];                  // stage 2 merge halves
    prod_q[1] <= prod_q[0] + {hi_q, {HALF{1'b0}}};
    for (int k = 2; k < MUL_STAGES; k++) begin  // remaining stages just carry
      tag_q[k]  <= tag_q[k-1];
      prod_q[k] <= prod_q[k-1];
    end
  end

  // low 32 bits only
  assign res_valid_o = v_q[MUL_STAGES-1];
  assign res_tag_o   = tag_q[MUL_STAGES-1];
  assign res_data_o  = prod_q[MUL_STAGES-1];

endmodule

`default_nettype wire

// File: source/issue_top.sv
`timescale 1ns/1ns
`default_nettype none

module issue_top
  import issue_pkg::*;
  ( input  logic    clk_i
  , input  logic    reset_i
  // dispatch port
  , input  logic    dispatch_valid_i
  , output logic    dispatch_ready_o
  , input  tag_t    dest_tag_i
  , input  tag_t    src1_tag_i
  , input  tag_t    src2_tag_i
  , input  logic    use_imm_i
  , input  opcode_t opcode_i
  , input  fu_sel_t fu_sel_i
  // external load return
  , input  logic    ld_valid_i
  , input  tag_t    ld_tag_i
  , input  word_t   ld_data_i
  // unit result buses
  , output logic    alu_valid_o
  , output tag_t    alu_tag_o
  , output word_t   alu_data_o
  , output logic    mul_valid_o
  , output tag_t    mul_tag_o
  , output word_t   mul_data_o
  );

  logic  src1_rdy;
  word_t src1_val;
  logic  src2_rdy;
  word_t src2_val;
  logic  alloc;     // dispatch handshake fires

  issue_if issue_bus ();

  assign alloc = dispatch_valid_i && dispatch_ready_o;

  issue_table u_issue_table (
    .clk_i, .reset_i,
    .dispatch_valid_i, .dispatch_ready_o,
    .dest_tag_i, .src1_tag_i, .src2_tag_i, .use_imm_i, .opcode_i, .fu_sel_i,
    .src1_rdy_i (src1_rdy), .src1_val_i (src1_val),
    .src2_rdy_i (src2_rdy), .src2_val_i (src2_val),
    .alu_res_valid_i (alu_valid_o), .alu_res_tag_i (alu_tag_o), .alu_res_data_i (alu_data_o),
    .mul_res_valid_i (mul_valid_o), .mul_res_tag_i (mul_tag_o), .mul_res_data_i (mul_data_o),
    .ld_res_valid_i  (ld_valid_i),  .ld_res_tag_i  (ld_tag_i),  .ld_res_data_i  (ld_data_i),
    .issue_o (issue_bus.tbl)
  );

  phys_reg_file u_phys_reg_file (
    .clk_i, .reset_i,
    .src1_tag_i, .src2_tag_i, .dest_tag_i,
    .alloc_i (alloc),
    .alu_res_valid_i (alu_valid_o), .alu_res_tag_i (alu_tag_o), .alu_res_data_i (alu_data_o),
    .mul_res_valid_i (mul_valid_o), .mul_res_tag_i (mul_tag_o), .mul_res_data_i (mul_data_o),
    .ld_res_valid_i  (ld_valid_i),  .ld_res_tag_i  (ld_tag_i),  .ld_res_data_i  (ld_data_i),
    .src1_rdy_o (src1_rdy), .src1_val_o (src1_val),
    .src2_rdy_o (src2_rdy), .src2_val_o (src2_val)
  );

  alu_unit u_alu_unit (
    .clk_i, .reset_i,
    .issue_i     (issue_bus.unit),
    .res_valid_o (alu_valid_o),
    .res_tag_o   (alu_tag_o),
    .res_data_o  (alu_data_o)
  );

  mul_unit u_mul_unit (
    .clk_i, .reset_i,
    .issue_i     (issue_bus.unit),
    .res_valid_o (mul_valid_o),
    .res_tag_o   (mul_tag_o),
    .res_data_o  (mul_data_o)
  );

endmodule

`default_nettype wire

// File: dv/issue_assert.sv
`timescale 1ns/1ns
`default_nettype none

module issue_assert
  import issue_pkg::*;
  ( input  logic                     clk_i
  , input  logic                     reset_i
  , input  count_t                   count_i
  , input  logic                     issue_valid_i
  , input  logic                     dispatch_ready_i
  , input  logic [ISSUE_ENTRIES-1:0] slot_valid_i
  );

  // one slot leaves per cycle at most
  single_issue: assert property (@(posedge clk_i) disable iff (reset_i)
    $countones($past(slot_valid_i) & ~slot_valid_i) <= 1)
    else $error("more than one entry left the table in one cycle");

  no_issue_when_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    (count_i == '0) |-> !issue_valid_i)
    else $error("issue valid with an empty table");

  // refused exactly when every slot is taken
  ready_tracks_full: assert property (@(posedge clk_i) disable iff (reset_i)
    (!dispatch_ready_i) == (&slot_valid_i))
    else $error("dispatch ready disagrees with occupancy");

  count_in_range: assert property (@(posedge clk_i) disable iff (reset_i)
    count_i <= count_t'(ISSUE_ENTRIES))
    else $error("occupancy above table depth");

endmodule

bind issue_table issue_assert u_issue_assert (
  .clk_i            (clk_i),
  .reset_i          (reset_i),
  .count_i          (count_q),
  .issue_valid_i    (issue),
  .dispatch_ready_i (dispatch_ready_o),
  .slot_valid_i     (ent_valid_q)
);

`default_nettype wire

// File: dv/issue_tb.sv
`timescale 1ns/1ns
`default_nettype none

module issue_tb
  import issue_pkg::*;
  ();

  typedef struct {
    tag_t    dest;
    tag_t    s1;
    tag_t    s2;
    logic    imm;
    opcode_t op;
    fu_sel_t fu;
    int      ld_delay;  // cycles from acceptance to a load beat on dest
    logic    seed;      // load beat only, no dispatch
    logic    ord;       // result one cycle after the previous row's result
    string   name;
  } row_t;

  logic    clk_i;
  logic    reset_i;
  logic    dispatch_valid_i;
  logic    dispatch_ready_o;
  tag_t    dest_tag_i;
  tag_t    src1_tag_i;
  tag_t    src2_tag_i;
  logic    use_imm_i;
  opcode_t opcode_i;
  fu_sel_t fu_sel_i;
  logic    ld_valid_i;
  tag_t    ld_tag_i;
  word_t   ld_data_i;
  logic    alu_valid_o;
  tag_t    alu_tag_o;
  word_t   alu_data_o;
  logic    mul_valid_o;
  tag_t    mul_tag_o;
  word_t   mul_data_o;

  row_t   rows [$];
  word_t  model [NUM_TAGS];   // register values in program order
  logic   exp_set [NUM_TAGS]; // a unit result is due for this tag
  logic   seen [NUM_TAGS];
  int     seen_at [NUM_TAGS];
  string  tag_name [NUM_TAGS];
  int     ld_due [$];         // pending load beats
  tag_t   ld_tag_q [$];
  word_t  ld_dat_q [$];
  int     cyc;
  int     limit;
  int     n_exp;
  int     n_seen;
  logic   saw_full;
  integer seed_v;

  issue_top issue_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin  // cycle count and run limit
    cyc <= cyc + 1;
    if (cyc > limit) fail_now("timeout, results still missing");
  end

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_equal(input string name, input word_t expv, input word_t actv);
    if (expv !== actv) begin
      $display("mismatch %s expected %h actual %h", name, expv, actv);
      fail_now("value check failed");
    end
  endtask

  task automatic add_row(input tag_t d, input tag_t a, input tag_t b, input logic im,
                         input opcode_t op, input fu_sel_t fu, input int dl,
                         input logic sd, input logic od, input string nm);
    row_t r;
    r = '{dest: d, s1: a, s2: b, imm: im, op: op, fu: fu, ld_delay: dl,
          seed: sd, ord: od, name: nm};
    rows.push_back(r);
  endtask

  function automatic word_t apply_op(input opcode_t op, input word_t a, input word_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      default: return a * b;  // low word of product
    endcase
  endfunction

  // result bus sampled mid-cycle
  task automatic check_beat(input tag_t t, input word_t d);
    if (!exp_set[t]) fail_now($sformatf("result on tag %0d that no instruction produces", t));
    if (seen[t]) fail_now($sformatf("tag %0d reported twice on the result buses", t));
    seen[t]    = 1'b1;
    seen_at[t] = cyc;
    n_seen++;
    check_equal(tag_name[t], model[t], d);
  endtask

  always @(negedge clk_i) begin
    if (!reset_i && alu_valid_o) check_beat(alu_tag_o, alu_data_o);
    if (!reset_i && mul_valid_o) check_beat(mul_tag_o, mul_data_o);
  end

  // next low phase, drops dispatch and serves one due load beat
  task automatic next_cycle();
    @(negedge clk_i);
    dispatch_valid_i = 1'b0;
    ld_valid_i       = 1'b0;
    if (ld_due.size() != 0 && ld_due[0] <= cyc) begin
      ld_valid_i = 1'b1;
      ld_tag_i   = ld_tag_q.pop_front();
      ld_data_i  = ld_dat_q.pop_front();
      void'(ld_due.pop_front());
    end
  endtask

  task automatic dispatch_row(input row_t r);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      next_cycle();
      dispatch_valid_i = 1'b1;
      dest_tag_i       = r.dest;
      src1_tag_i       = r.s1;
      src2_tag_i       = r.s2;
      use_imm_i        = r.imm;
      opcode_i         = r.op;
      fu_sel_i         = r.fu;
      #1;
      if (dispatch_ready_o) taken = 1'b1;  // taken at the coming edge
      else saw_full = 1'b1;
    end
    if (r.ld_delay != 0) begin
      ld_due.push_back(cyc + 1 + r.ld_delay);
      ld_tag_q.push_back(r.dest);
      ld_dat_q.push_back(model[r.dest]);
    end
  endtask

  initial begin
    word_t b;
    dispatch_valid_i = 1'b0;
    dest_tag_i = '0;
    src1_tag_i = '0;
    src2_tag_i = '0;
    use_imm_i  = 1'b0;
    opcode_i   = OP_ADD;
    fu_sel_i   = FU_ALU;
    ld_valid_i = 1'b0;
    ld_tag_i   = '0;
    ld_data_i  = '0;
    reset_i    = 1'b1;
    cyc = 0;
    n_exp = 0;
    n_seen = 0;
    saw_full = 1'b0;
    seed_v = 64788;
    // tag 0 stays zero, tag 31 holds random load data
    add_row(5'd31, 5'd0,  5'd0,  1'b0, OP_ADD, FU_ALU, 0, 1'b1, 1'b0, "seed load");
    add_row(5'd1,  5'd0,  5'd7,  1'b1, OP_ADD, FU_ALU, 0, 1'b0, 1'b0, "imm add");
    add_row(5'd2,  5'd0,  5'd3,  1'b1, OP_SUB, FU_ALU, 0, 1'b0, 1'b0, "imm sub");
    add_row(5'd3,  5'd0,  5'd31, 1'b1, OP_AND, FU_ALU, 0, 1'b0, 1'b0, "imm and");
    add_row(5'd4,  5'd0,  5'd21, 1'b1, OP_OR,  FU_ALU, 0, 1'b0, 1'b0, "imm or");
    add_row(5'd5,  5'd0,  5'd9,  1'b1, OP_XOR, FU_ALU, 0, 1'b0, 1'b0, "imm xor");
    add_row(5'd6,  5'd31, 5'd5,  1'b1, OP_ADD, FU_ALU, 0, 1'b0, 1'b0, "chain add");
    add_row(5'd7,  5'd6,  5'd13, 1'b1, OP_MUL, FU_MUL, 0, 1'b0, 1'b0, "chain mul");
    add_row(5'd8,  5'd7,  5'd6,  1'b0, OP_SUB, FU_ALU, 0, 1'b0, 1'b0, "chain mul to sub");
    add_row(5'd9,  5'd8,  5'd6,  1'b0, OP_MUL, FU_MUL, 0, 1'b0, 1'b0, "chain reg mul");
    add_row(5'd10, 5'd31, 5'd1,  1'b1, OP_MUL, FU_MUL, 2, 1'b0, 1'b0, "load producer");
    add_row(5'd11, 5'd10, 5'd4,  1'b1, OP_ADD, FU_ALU, 0, 1'b0, 1'b0, "load wait add");
    add_row(5'd12, 5'd10, 5'd6,  1'b0, OP_AND, FU_ALU, 0, 1'b0, 1'b0, "load wait and");
    add_row(5'd13, 5'd31, 5'd1,  1'b1, OP_MUL, FU_MUL, 2, 1'b0, 1'b0, "age producer");
    add_row(5'd14, 5'd13, 5'd2,  1'b1, OP_OR,  FU_ALU, 0, 1'b0, 1'b0, "age first");
    add_row(5'd15, 5'd13, 5'd5,  1'b1, OP_XOR, FU_ALU, 0, 1'b0, 1'b1, "age second");
    add_row(5'd16, 5'd13, 5'd1,  1'b1, OP_SUB, FU_ALU, 0, 1'b0, 1'b1, "age third");
    add_row(5'd17, 5'd31, 5'd7,  1'b1, OP_MUL, FU_MUL, 0, 1'b0, 1'b0, "pipe mul a");
    add_row(5'd18, 5'd31, 5'd9,  1'b1, OP_MUL, FU_MUL, 0, 1'b0, 1'b1, "pipe mul b");
    add_row(5'd19, 5'd31, 5'd3,  1'b1, OP_MUL, FU_MUL, 0, 1'b0, 1'b0, "full chain 1");
    add_row(5'd20, 5'd19, 5'd5,  1'b1, OP_MUL, FU_MUL, 0, 1'b0, 1'b0, "full chain 2");
    add_row(5'd21, 5'd20, 5'd7,  1'b1, OP_MUL, FU_MUL, 0, 1'b0, 1'b0, "full chain 3");
    add_row(5'd22, 5'd21, 5'd9,  1'b1, OP_MUL, FU_MUL, 9, 1'b0, 1'b0, "full chain 4");
    add_row(5'd23, 5'd22, 5'd1,  1'b1, OP_ADD, FU_ALU, 0, 1'b0, 1'b0, "full dep 1");
    add_row(5'd24, 5'd22, 5'd2,  1'b1, OP_SUB, FU_ALU, 0, 1'b0, 1'b0, "full dep 2");
    add_row(5'd25, 5'd22, 5'd3,  1'b1, OP_AND, FU_ALU, 0, 1'b0, 1'b0, "full dep 3");
    add_row(5'd26, 5'd22, 5'd4,  1'b1, OP_OR,  FU_ALU, 0, 1'b0, 1'b0, "full dep 4");
    add_row(5'd27, 5'd22, 5'd5,  1'b1, OP_XOR, FU_ALU, 0, 1'b0, 1'b0, "full dep 5");
    add_row(5'd28, 5'd22, 5'd6,  1'b1, OP_ADD, FU_ALU, 0, 1'b0, 1'b0, "full dep 6");
    add_row(5'd29, 5'd22, 5'd7,  1'b1, OP_SUB, FU_ALU, 0, 1'b0, 1'b0, "full dep 7");
    add_row(5'd30, 5'd22, 5'd8,  1'b1, OP_XOR, FU_ALU, 0, 1'b0, 1'b0, "full dep 8");
    limit = 40 * rows.size() + 100;
    for (int t = 0; t < NUM_TAGS; t++) begin
      model[t]   = '0;
      exp_set[t] = 1'b0;
      seen[t]    = 1'b0;
      seen_at[t] = 0;
    end
    foreach (rows[r]) begin  // reference values in program order
      if (rows[r].seed) begin
        model[rows[r].dest] = $random(seed_v);
      end else begin
        b = rows[r].imm ? word_t'(rows[r].s2) : model[rows[r].s2];
        model[rows[r].dest]    = apply_op(rows[r].op, model[rows[r].s1], b);
        exp_set[rows[r].dest]  = 1'b1;
        tag_name[rows[r].dest] = rows[r].name;
        n_exp++;
      end
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    foreach (rows[r]) begin
      if (rows[r].seed) begin
        ld_due.push_back(cyc);  // served with the next dispatch
        ld_tag_q.push_back(rows[r].dest);
        ld_dat_q.push_back(model[rows[r].dest]);
      end else begin
        dispatch_row(rows[r]);
      end
    end
    while (n_seen < n_exp || ld_due.size() != 0) next_cycle();
    for (int r = 1; r < rows.size(); r++) begin
      if (rows[r].ord && seen_at[rows[r].dest] != seen_at[rows[r-1].dest] + 1)
        fail_now($sformatf("%s did not come back one cycle after the older instruction",
                           rows[r].name));
    end
    if (!saw_full) begin
      fail_now("dispatch was never refused by a full table");
    end else begin
      repeat (2) next_cycle();
      check_equal("ready after drain", word_t'(1), word_t'(dispatch_ready_o));
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: build.f
source/issue_pkg.sv
source/issue_if.sv
source/phys_reg_file.sv
source/issue_table.sv
source/alu_unit.sv
source/mul_unit.sv
source/issue_top.sv
dv/issue_assert.sv
dv/issue_tb.sv

// File: run.sh
#!/bin/sh
# build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module issue_tb \
  -Mdir obj_dir -o issue_sim
status=$?
if [ $status -ne 0 ]; then
  echo "compile step failed with status $status"
  exit 1
fi

out=$(./obj_dir/issue_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Test OK"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
